//--- cpu_pkg.sv
package cpu_pkg;

	// Datapath and storage sizes
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;
	localparam int SHAMT_W    = $clog2(XLEN);
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
	localparam int OPCODE_W   = 6;
	localparam int FUNC_W     = 6;
	localparam int ALU_OP_W   = 5;
	localparam int IMM_W      = 16;
	localparam int TARGET_W   = 26;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;	// jal writes here

	// Instruction field positions
	localparam int OP_HI  = 31;
	localparam int OP_LO  = 26;
	localparam int RS_HI  = 25;
	localparam int RS_LO  = 21;
	localparam int RT_HI  = 20;
	localparam int RT_LO  = 16;
	localparam int RD_HI  = 15;
	localparam int RD_LO  = 11;
	localparam int FN_HI  = 5;
	localparam int FN_LO  = 0;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;
	localparam int TGT_HI = 25;
	localparam int TGT_LO = 0;

	// Opcodes
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'd0;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'd1;
	localparam logic [OPCODE_W-1:0] OP_SUBI  = 6'd2;
	localparam logic [OPCODE_W-1:0] OP_MULI  = 6'd3;
	localparam logic [OPCODE_W-1:0] OP_DIVI  = 6'd4;
	localparam logic [OPCODE_W-1:0] OP_MODI  = 6'd5;
	localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'd6;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'd7;
	localparam logic [OPCODE_W-1:0] OP_XORI  = 6'd8;
	localparam logic [OPCODE_W-1:0] OP_NOT   = 6'd9;
	localparam logic [OPCODE_W-1:0] OP_LANDI = 6'd10;
	localparam logic [OPCODE_W-1:0] OP_LORI  = 6'd11;
	localparam logic [OPCODE_W-1:0] OP_SLLI  = 6'd12;
	localparam logic [OPCODE_W-1:0] OP_SRLI  = 6'd13;
	localparam logic [OPCODE_W-1:0] OP_MOV   = 6'd14;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'd15;
	localparam logic [OPCODE_W-1:0] OP_LI    = 6'd16;
	localparam logic [OPCODE_W-1:0] OP_LA    = 6'd17;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'd18;
	localparam logic [OPCODE_W-1:0] OP_IN    = 6'd19;
	localparam logic [OPCODE_W-1:0] OP_OUT   = 6'd20;
	localparam logic [OPCODE_W-1:0] OP_JF    = 6'd21;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'd22;
	localparam logic [OPCODE_W-1:0] OP_JAL   = 6'd23;
	localparam logic [OPCODE_W-1:0] OP_HALT  = 6'd24;

	// R-type function codes
	localparam logic [FUNC_W-1:0] FN_ADD  = 6'd0;
	localparam logic [FUNC_W-1:0] FN_SUB  = 6'd1;
	localparam logic [FUNC_W-1:0] FN_MUL  = 6'd2;
	localparam logic [FUNC_W-1:0] FN_DIV  = 6'd3;
	localparam logic [FUNC_W-1:0] FN_MOD  = 6'd4;
	localparam logic [FUNC_W-1:0] FN_AND  = 6'd5;
	localparam logic [FUNC_W-1:0] FN_OR   = 6'd6;
	localparam logic [FUNC_W-1:0] FN_XOR  = 6'd7;
	localparam logic [FUNC_W-1:0] FN_LAND = 6'd8;
	localparam logic [FUNC_W-1:0] FN_LOR  = 6'd9;
	localparam logic [FUNC_W-1:0] FN_SLL  = 6'd10;
	localparam logic [FUNC_W-1:0] FN_SRL  = 6'd11;
	localparam logic [FUNC_W-1:0] FN_EQ   = 6'd12;
	localparam logic [FUNC_W-1:0] FN_NE   = 6'd13;
	localparam logic [FUNC_W-1:0] FN_LT   = 6'd14;
	localparam logic [FUNC_W-1:0] FN_LE   = 6'd15;
	localparam logic [FUNC_W-1:0] FN_GT   = 6'd16;
	localparam logic [FUNC_W-1:0] FN_GE   = 6'd17;
	localparam logic [FUNC_W-1:0] FN_JR   = 6'd18;

	// ALU operations, bit 4 marks the compare group
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 5'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 5'd1;
	localparam logic [ALU_OP_W-1:0] ALU_MUL    = 5'd2;
	localparam logic [ALU_OP_W-1:0] ALU_DIV    = 5'd3;
	localparam logic [ALU_OP_W-1:0] ALU_MOD    = 5'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 5'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 5'd6;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 5'd8;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 5'd9;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 5'd10;
	localparam logic [ALU_OP_W-1:0] ALU_NOT    = 5'd11;
	localparam logic [ALU_OP_W-1:0] ALU_LAND   = 5'd12;
	localparam logic [ALU_OP_W-1:0] ALU_LOR    = 5'd13;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_A = 5'd14;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 5'd15;
	localparam logic [ALU_OP_W-1:0] ALU_EQ     = 5'd16;
	localparam logic [ALU_OP_W-1:0] ALU_NE     = 5'd17;
	localparam logic [ALU_OP_W-1:0] ALU_LT     = 5'd18;
	localparam logic [ALU_OP_W-1:0] ALU_LE     = 5'd19;
	localparam logic [ALU_OP_W-1:0] ALU_GT     = 5'd20;
	localparam logic [ALU_OP_W-1:0] ALU_GE     = 5'd21;

	// Next PC sources
	localparam logic [1:0] PC_NEXT   = 2'd0;
	localparam logic [1:0] PC_IMM    = 2'd1;
	localparam logic [1:0] PC_REG    = 2'd2;
	localparam logic [1:0] PC_TARGET = 2'd3;

	// Write-back sources
	localparam logic [1:0] WB_ALU   = 2'd0;
	localparam logic [1:0] WB_MEM   = 2'd1;
	localparam logic [1:0] WB_INPUT = 2'd2;
	localparam logic [1:0] WB_LINK  = 2'd3;

	typedef struct packed {
		logic                reg_write;
		logic                mem_write;
		logic                alu_src_reg;	// 1 selects rt, 0 the immediate
		logic                rt_dest;
		logic                is_jal;
		logic                out_write;
		logic                is_halt;
		logic                is_input;	// in instruction with data offered
		logic [1:0]          pc_source;
		logic [1:0]          wb_select;
		logic [ALU_OP_W-1:0] alu_op;
	} ctrl_t;

endpackage

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic [cpu_pkg::OPCODE_W-1:0] i_op,
	input  logic [cpu_pkg::FUNC_W-1:0]   i_func,
	input  logic                         i_rs_zero,	// Jump-if-false condition
	input  logic                         i_in_valid,
	output cpu_pkg::ctrl_t               o_ctrl
);
	import cpu_pkg::*;

	// R-type
	logic rtype;
	logic is_add, is_sub, is_mul, is_div, is_mod;
	logic is_and, is_or, is_xor, is_land, is_lor;
	logic is_sll, is_srl;
	logic is_eq, is_ne, is_lt, is_le, is_gt, is_ge;
	logic is_jr;

	// I-type and J-type
	logic is_addi, is_subi, is_muli, is_divi, is_modi;
	logic is_andi, is_ori, is_xori, is_not, is_landi, is_lori;
	logic is_slli, is_srli;
	logic is_mov, is_lw, is_li, is_la, is_sw;
	logic is_in, is_out, is_jf;
	logic is_j, is_jal, is_halt;

	assign rtype   = (i_op == OP_RTYPE);
	assign is_add  = rtype & (i_func == FN_ADD);
	assign is_sub  = rtype & (i_func == FN_SUB);
	assign is_mul  = rtype & (i_func == FN_MUL);
	assign is_div  = rtype & (i_func == FN_DIV);
	assign is_mod  = rtype & (i_func == FN_MOD);
	assign is_and  = rtype & (i_func == FN_AND);
	assign is_or   = rtype & (i_func == FN_OR);
	assign is_xor  = rtype & (i_func == FN_XOR);
	assign is_land = rtype & (i_func == FN_LAND);
	assign is_lor  = rtype & (i_func == FN_LOR);
	assign is_sll  = rtype & (i_func == FN_SLL);
	assign is_srl  = rtype & (i_func == FN_SRL);
	assign is_eq   = rtype & (i_func == FN_EQ);
	assign is_ne   = rtype & (i_func == FN_NE);
	assign is_lt   = rtype & (i_func == FN_LT);
	assign is_le   = rtype & (i_func == FN_LE);
	assign is_gt   = rtype & (i_func == FN_GT);
	assign is_ge   = rtype & (i_func == FN_GE);
	assign is_jr   = rtype & (i_func == FN_JR);

	assign is_addi  = (i_op == OP_ADDI);
	assign is_subi  = (i_op == OP_SUBI);
	assign is_muli  = (i_op == OP_MULI);
	assign is_divi  = (i_op == OP_DIVI);
	assign is_modi  = (i_op == OP_MODI);
	assign is_andi  = (i_op == OP_ANDI);
	assign is_ori   = (i_op == OP_ORI);
	assign is_xori  = (i_op == OP_XORI);
	assign is_not   = (i_op == OP_NOT);
	assign is_landi = (i_op == OP_LANDI);
	assign is_lori  = (i_op == OP_LORI);
	assign is_slli  = (i_op == OP_SLLI);
	assign is_srli  = (i_op == OP_SRLI);
	assign is_mov   = (i_op == OP_MOV);
	assign is_lw    = (i_op == OP_LW);
	assign is_li    = (i_op == OP_LI);
	assign is_la    = (i_op == OP_LA);
	assign is_sw    = (i_op == OP_SW);
	assign is_in    = (i_op == OP_IN);
	assign is_out   = (i_op == OP_OUT);
	assign is_jf    = (i_op == OP_JF);
	assign is_j     = (i_op == OP_J);
	assign is_jal   = (i_op == OP_JAL);
	assign is_halt  = (i_op == OP_HALT);

	assign o_ctrl.reg_write = is_add | is_sub | is_mul | is_div | is_mod |
		is_addi | is_subi | is_muli | is_divi | is_modi |
		is_and | is_or | is_xor | is_land | is_lor | is_not |
		is_andi | is_ori | is_xori | is_landi | is_lori |
		is_sll | is_srl | is_slli | is_srli |
		is_mov | is_lw | is_li | is_la | is_in | is_jal |
		is_eq | is_ne | is_lt | is_le | is_gt | is_ge;
	assign o_ctrl.mem_write = is_sw;
	assign o_ctrl.alu_src_reg = is_add | is_sub | is_mul | is_div | is_mod |
		is_and | is_or | is_xor | is_land | is_lor |
		is_sll | is_srl | is_mov |
		is_eq | is_ne | is_lt | is_le | is_gt | is_ge;
	assign o_ctrl.rt_dest = is_addi | is_subi | is_muli | is_divi | is_modi |
		is_andi | is_ori | is_xori | is_not | is_landi | is_lori |
		is_slli | is_srli |
		is_mov | is_lw | is_li | is_la | is_in;
	assign o_ctrl.is_jal    = is_jal;
	assign o_ctrl.out_write = is_out;
	assign o_ctrl.is_halt   = is_halt;
	assign o_ctrl.is_input  = is_in & i_in_valid;

	assign o_ctrl.pc_source[0] = is_j | is_jal | (is_jf & i_rs_zero);
	assign o_ctrl.pc_source[1] = is_j | is_jr | is_jal;
	assign o_ctrl.wb_select[0] = is_lw | is_jal;	// Memory or link
	assign o_ctrl.wb_select[1] = is_in | is_jal;	// Input or link

	// ALU operation bits, grouped by encoding bit
	assign o_ctrl.alu_op[0] = is_sub | is_div | is_sll | is_or | is_lor | is_not |
		is_subi | is_divi | is_slli | is_ori | is_lori |
		is_li | is_ne | is_le | is_ge | is_jf;
	assign o_ctrl.alu_op[1] = is_mul | is_div | is_xor | is_srl | is_lt | is_le | is_not |
		is_muli | is_divi | is_xori | is_srli |
		is_mov | is_li | is_jr | is_out | is_jf;
	assign o_ctrl.alu_op[2] = is_mod | is_sll | is_srl | is_land | is_lor | is_gt | is_ge |
		is_modi | is_slli | is_srli | is_landi | is_lori |
		is_mov | is_li | is_jr | is_out | is_jf;
	assign o_ctrl.alu_op[3] = is_and | is_or | is_xor | is_land | is_lor | is_not |
		is_andi | is_ori | is_xori | is_landi | is_lori |
		is_mov | is_li | is_jr | is_out | is_jf;
	assign o_ctrl.alu_op[4] = is_eq | is_ne | is_lt | is_le | is_gt | is_ge;	// Compare group

	always_comb begin
		assert (!(o_ctrl.mem_write && o_ctrl.reg_write));	// Store never writes back
		assert (!o_ctrl.is_jal || (o_ctrl.pc_source == PC_TARGET));
	end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [cpu_pkg::ALU_OP_W-1:0] i_op,
	input  logic [cpu_pkg::XLEN-1:0]     i_a,
	input  logic [cpu_pkg::XLEN-1:0]     i_b,
	output logic [cpu_pkg::XLEN-1:0]     o_result
);
	import cpu_pkg::*;

	logic signed [XLEN-1:0] a_s;
	logic signed [XLEN-1:0] b_s;
	logic [SHAMT_W-1:0]     shamt;
	logic                   a_true;
	logic                   b_true;
	logic                   b_zero;
	logic                   cmp;

	assign a_s    = i_a;
	assign b_s    = i_b;
	assign shamt  = i_b[SHAMT_W-1:0];	// Low 5 bits only
	assign a_true = |i_a;
	assign b_true = |i_b;
	assign b_zero = ~b_true;

	// Signed compares, selected by the low op bits
	always_comb begin
		case (i_op)
			ALU_EQ:  cmp = (a_s == b_s);
			ALU_NE:  cmp = (a_s != b_s);
			ALU_LT:  cmp = (a_s < b_s);
			ALU_LE:  cmp = (a_s <= b_s);
			ALU_GT:  cmp = (a_s > b_s);
			ALU_GE:  cmp = (a_s >= b_s);
			default: cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_MUL:    o_result = i_a * i_b;
			ALU_DIV:    o_result = b_zero ? '0 : i_a / i_b;	// Divide by zero gives 0
			ALU_MOD:    o_result = b_zero ? '0 : i_a % i_b;
			ALU_SLL:    o_result = i_a << shamt;
			ALU_SRL:    o_result = i_a >> shamt;
			ALU_AND:    o_result = i_a & i_b;
			ALU_OR:     o_result = i_a | i_b;
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_NOT:    o_result = ~i_a;
			ALU_LAND:   o_result = {{(XLEN-1){1'b0}}, a_true & b_true};
			ALU_LOR:    o_result = {{(XLEN-1){1'b0}}, a_true | b_true};
			ALU_PASS_A: o_result = i_a;	// mov, jr, out
			ALU_PASS_B: o_result = i_b;	// li, jf
			default:    o_result = {{(XLEN-1){1'b0}}, cmp};
		endcase
		if (i_op[4]) begin
			assert (o_result[XLEN-1:1] == '0);	// Compare result is a single bit
		end
	end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_waddr,
	input  logic [cpu_pkg::XLEN-1:0]       i_wdata,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_raddr_a,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_raddr_b,
	output logic [cpu_pkg::XLEN-1:0]       o_rdata_a,
	output logic [cpu_pkg::XLEN-1:0]       o_rdata_b
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [0:NUM_REGS-1];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_waddr != '0)) begin	// r0 stays zero
			regs[i_waddr] <= i_wdata;
		end
	end

	// Asynchronous reads
	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

//--- instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory (
	input  logic                        i_clk,
	input  logic                        i_load_we,	// Already gated by reset in the top
	input  logic [cpu_pkg::IMEM_AW-1:0] i_load_addr,
	input  logic [cpu_pkg::XLEN-1:0]    i_load_data,
	input  logic [cpu_pkg::IMEM_AW-1:0] i_addr,
	output logic [cpu_pkg::XLEN-1:0]    o_instr
);
	import cpu_pkg::*;

	logic [XLEN-1:0] mem [0:IMEM_DEPTH-1];

	always_ff @(posedge i_clk) begin
		if (i_load_we) begin
			mem[i_load_addr] <= i_load_data;
		end
	end

	assign o_instr = mem[i_addr];	// Fetch at the PC

	// A load implies the core is held in reset, so the fetch address is parked at 0
	assert property (@(posedge i_clk) i_load_we |=> (i_addr == '0));

endmodule

//--- data_memory.sv
`timescale 1ns/1ps

module data_memory (
	input  logic                     i_clk,
	input  logic                     i_we,
	input  logic [cpu_pkg::XLEN-1:0] i_addr,
	input  logic [cpu_pkg::XLEN-1:0] i_wdata,
	output logic [cpu_pkg::XLEN-1:0] o_rdata
);
	import cpu_pkg::*;

	logic [XLEN-1:0]    mem [0:DMEM_DEPTH-1];
	logic [DMEM_AW-1:0] word_addr;

	assign word_addr = i_addr[DMEM_AW-1:0];	// Wraps on the low bits

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[word_addr] <= i_wdata;
		end
	end

	assign o_rdata = mem[word_addr];

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_load_we,
	input  logic [cpu_pkg::IMEM_AW-1:0] i_load_addr,
	input  logic [cpu_pkg::XLEN-1:0]    i_load_data,
	input  logic                        i_in_valid,
	input  logic [cpu_pkg::XLEN-1:0]    i_in_data,
	output logic                        o_out_valid,
	output logic [cpu_pkg::XLEN-1:0]    o_out_data,
	output logic                        o_in_wait,
	output logic                        o_halted,
	output logic [cpu_pkg::XLEN-1:0]    o_pc
);
	import cpu_pkg::*;

	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       pc_plus1;
	logic [XLEN-1:0]       pc_next;
	logic [XLEN-1:0]       instr;
	logic [XLEN-1:0]       imm_ext;
	logic [XLEN-1:0]       target_ext;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_result;
	logic [XLEN-1:0]       mem_rdata;
	logic [XLEN-1:0]       wb_data;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] wb_dest;
	ctrl_t                 ctrl;
	logic                  halted;
	logic                  stall;
	logic                  active;
	logic                  load_we;

	assign rs = instr[RS_HI:RS_LO];
	assign rt = instr[RT_HI:RT_LO];
	assign rd = instr[RD_HI:RD_LO];
	assign imm_ext    = {{(XLEN-IMM_W){instr[IMM_HI]}}, instr[IMM_HI:IMM_LO]};
	assign target_ext = {{(XLEN-TARGET_W){1'b0}}, instr[TGT_HI:TGT_LO]};
	assign pc_plus1   = pc + 1'b1;

	// in waits until data is offered
	assign stall   = (instr[OP_HI:OP_LO] == OP_IN) & ~ctrl.is_input;
	assign active  = ~stall & ~halted;
	assign load_we = i_load_we & ~i_rst_n;	// Program load only in reset

	assign alu_b   = ctrl.alu_src_reg ? rt_data : imm_ext;
	assign wb_dest = ctrl.is_jal ? LINK_REG : (ctrl.rt_dest ? rt : rd);

	always_comb begin
		case (ctrl.wb_select)
			WB_ALU:   wb_data = alu_result;
			WB_MEM:   wb_data = mem_rdata;
			WB_INPUT: wb_data = i_in_data;
			default:  wb_data = pc_plus1;	// Link address
		endcase
	end

	always_comb begin
		case (ctrl.pc_source)
			PC_NEXT: pc_next = pc_plus1;
			PC_IMM:  pc_next = imm_ext;	// jf taken
			PC_REG:  pc_next = rs_data;
			default: pc_next = target_ext;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			if (ctrl.is_halt) begin
				halted <= 1'b1;
			end
			if (active && !ctrl.is_halt) begin	// PC parks on halt
				pc <= pc_next;
			end
		end
	end

	assign o_pc        = pc;
	assign o_halted    = halted;
	assign o_in_wait   = stall & ~halted;
	assign o_out_valid = ctrl.out_write & active;
	assign o_out_data  = alu_result;	// rs through PASS_A

	instruction_memory u_imem (
		.i_clk       (i_clk),
		.i_load_we   (load_we),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_addr      (pc[IMEM_AW-1:0]),
		.o_instr     (instr)
	);

	control_unit u_ctrl (
		.i_op       (instr[OP_HI:OP_LO]),
		.i_func     (instr[FN_HI:FN_LO]),
		.i_rs_zero  (rs_data == '0),
		.i_in_valid (i_in_valid),
		.o_ctrl     (ctrl)
	);

	register_file u_regs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_we      (ctrl.reg_write & active),
		.i_waddr   (wb_dest),
		.i_wdata   (wb_data),
		.i_raddr_a (rs),
		.i_raddr_b (rt),
		.o_rdata_a (rs_data),
		.o_rdata_b (rt_data)
	);

	alu u_alu (
		.i_op     (ctrl.alu_op),
		.i_a      (rs_data),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

	data_memory u_dmem (
		.i_clk   (i_clk),
		.i_we    (ctrl.mem_write & active),
		.i_addr  (alu_result),
		.i_wdata (rt_data),
		.o_rdata (mem_rdata)
	);

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	localparam int NUM_PROGS      = 8;
	localparam int MAX_LEN        = 60;
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * (MAX_LEN * 8 + 40) + 200;
	localparam logic [31:0] LFSR_SEED = 32'd19737;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic              i_clk;
	logic              i_rst_n;
	logic              i_load_we;
	logic [IMEM_AW-1:0] i_load_addr;
	logic [XLEN-1:0]   i_load_data;
	logic              i_in_valid;
	logic [XLEN-1:0]   i_in_data;
	logic              o_out_valid;
	logic [XLEN-1:0]   o_out_data;
	logic              o_in_wait;
	logic              o_halted;
	logic [XLEN-1:0]   o_pc;

	logic [31:0] lfsr;
	logic [31:0] prog [0:63];
	logic [31:0] in_vals [0:63];	// Input values, offered in order
	logic [31:0] model_regs [0:31];
	logic [31:0] model_mem [0:255];
	logic [31:0] exp_out [$];
	logic [31:0] model_pc;
	int          prog_len;
	int          gen_pc;
	int          errors;
	int          checks;
	int          cycle_count;

	cpu_top UUT (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_load_we   (i_load_we),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_in_wait   (o_in_wait),
		.o_halted    (o_halted),
		.o_pc        (o_pc)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: no halt within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic random_bit();
		logic [31:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] enc_r(input int fn, input int rd, input int rs, input int rt);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn[5:0]};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input int target);
		return {op, target[25:0]};
	endfunction

	function automatic logic [31:0] out_of(input int r);
		return enc_i(OP_OUT, 0, r, 0);
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[gen_pc] = w;
		gen_pc++;
	endtask

	// Straight-line ALU work, also skipped over by forward jumps
	task automatic add_filler(input int n);
		for (int i = 0; i < n; i++) begin
			emit(enc_r(rand_bits(5) % 18, rand_bits(3), rand_bits(3), rand_bits(3)));
		end
	endtask

	task automatic make_program();
		int kind;
		int goal;
		int k;
		int t;
		int r;
		int rd;
		int rs;
		int rt;
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
			in_vals[i] = rand_bits(32);
		end
		gen_pc = 0;
		emit(enc_i(OP_LI, 1, 0, rand_bits(16)));	// Quiet first word
		goal = 40 + rand_bits(4);	// Longest block is 5, so length stays within 60
		while (gen_pc < goal) begin
			kind = rand_bits(4);
			rd = rand_bits(3);
			rs = rand_bits(3);
			rt = rand_bits(3);
			k = rand_bits(2);
			case (kind)
				0, 1, 2, 3: begin
					emit(enc_r(rand_bits(5) % 18, rd, rs, rt));
					emit(out_of(rd));
				end
				4, 5: begin
					t = 1 + rand_bits(4) % 13;	// addi through srli
					emit(enc_i(t[5:0], rt, rs, rand_bits(16)));
					emit(out_of(rt));
				end
				6: begin
					emit(enc_i(OP_LI, rt, 0, rand_bits(16)));
					emit(out_of(rt));
				end
				7: begin
					emit(enc_i(OP_LA, rt, rs, rand_bits(16)));
					emit(enc_i(OP_MOV, rd, rt, 0));
					emit(out_of(rd));
				end
				8: begin
					t = rand_bits(16);
					emit(enc_i(OP_SW, rt, rs, t));
					emit(enc_i(OP_LW, rd, rs, t));
					emit(out_of(rd));
				end
				9, 10: begin
					emit(enc_i(OP_IN, rt, 0, 0));
					emit(out_of(rt));
				end
				11: begin
					emit(enc_j(OP_J, gen_pc + 1 + k));
					add_filler(k);
				end
				12: begin
					emit(enc_j(OP_JAL, gen_pc + 1 + k));
					add_filler(k);
					emit(out_of(31));	// Link value
				end
				13: begin
					r = 1 + rand_bits(3) % 7;
					t = rand_bits(1);
					emit(enc_i(OP_LI, r, 0, t ? 0 : rand_bits(15) * 2 + 1));
					emit(enc_i(OP_JF, 0, r, gen_pc + 1 + k));
					add_filler(k);
				end
				14: begin
					emit(enc_i(OP_LI, 30, 0, gen_pc + 2 + k));
					emit(enc_r(int'(FN_JR), 0, 30, 0));
					add_filler(k);
				end
				default: add_filler(1);
			endcase
		end
		emit(enc_j(OP_HALT, 0));
		prog_len = gen_pc;
	endtask

	function automatic logic [31:0] alu_model(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b);
		case (fn)
			FN_ADD:  return a + b;
			FN_SUB:  return a - b;
			FN_MUL:  return a * b;
			FN_DIV:  return (b == 0) ? 32'd0 : a / b;
			FN_MOD:  return (b == 0) ? 32'd0 : a % b;
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_LAND: return (a != 0 && b != 0) ? 32'd1 : 32'd0;
			FN_LOR:  return (a != 0 || b != 0) ? 32'd1 : 32'd0;
			FN_SLL:  return a << b[4:0];
			FN_SRL:  return a >> b[4:0];
			FN_EQ:   return (a == b) ? 32'd1 : 32'd0;
			FN_NE:   return (a != b) ? 32'd1 : 32'd0;
			FN_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
			FN_GT:   return ($signed(a) > $signed(b)) ? 32'd1 : 32'd0;
			FN_GE:   return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	// Instruction-level reference, one loop pass per instruction
	task automatic run_model();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] pc;
		logic [31:0] nxt;
		logic [31:0] val;
		logic [5:0]  op;
		logic [4:0]  dst;
		logic        we;
		bit          done;
		int          steps;
		int          in_k;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		exp_out.delete();
		pc = '0;
		done = 0;
		steps = 0;
		in_k = 0;
		while (!done && steps < 200) begin
			w = prog[pc[5:0]];
			op = w[31:26];
			a = model_regs[w[25:21]];
			b = model_regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = a + imm;
			nxt = pc + 32'd1;
			we = 1'b1;
			dst = w[20:16];
			val = '0;
			case (op)
				OP_RTYPE: begin
					dst = w[15:11];
					val = alu_model(w[5:0], a, b);
					if (w[5:0] == FN_JR) begin
						we = 1'b0;
						nxt = a;
					end
				end
				OP_NOT:  val = ~a;
				OP_MOV:  val = a;
				OP_LW:   val = model_mem[addr[7:0]];
				OP_LI:   val = imm;
				OP_LA:   val = addr;
				OP_IN: begin
					val = in_vals[in_k];
					in_k++;
				end
				OP_SW: begin
					we = 1'b0;
					model_mem[addr[7:0]] = b;
				end
				OP_OUT: begin
					we = 1'b0;
					exp_out.push_back(a);
				end
				OP_JF: begin
					we = 1'b0;
					if (a == 0) begin
						nxt = imm;
					end
				end
				OP_J: begin
					we = 1'b0;
					nxt = {6'd0, w[25:0]};
				end
				OP_JAL: begin
					dst = 5'd31;
					val = pc + 32'd1;
					nxt = {6'd0, w[25:0]};
				end
				OP_HALT: begin
					we = 1'b0;
					done = 1;
				end
				default: val = alu_model((op < OP_NOT) ? op - 6'd1 : op - 6'd2, a, imm);
			endcase
			if (we && dst != 0) begin
				model_regs[dst] = val;
			end
			if (!done) begin
				pc = nxt;
			end
			steps++;
		end
		model_pc = pc;
	endtask

	// Reset for 10 cycles, then load while still in reset
	task automatic load_and_reset();
		@(posedge i_clk);
		i_rst_n <= 1'b0;
		i_load_we <= 1'b0;
		i_in_valid <= 1'b0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		for (int a = 0; a < prog_len; a++) begin
			i_load_we <= 1'b1;
			i_load_addr <= a[7:0];
			i_load_data <= prog[a];
			@(posedge i_clk);
		end
		i_load_we <= 1'b0;
		i_rst_n <= 1'b1;
		i_in_data <= in_vals[0];
		i_in_valid <= random_bit();
	endtask

	task automatic run_program();
		logic [5:0]  op;
		logic [31:0] halt_pc;
		logic        exp_wait;
		logic        accepted;
		bit          halt_seen;
		bit          halt_due;
		bit          first;
		int          out_idx;
		int          in_idx;
		int          after_halt;
		halt_pc = '0;
		halt_seen = 0;
		halt_due = 0;
		first = 1;
		out_idx = 0;
		in_idx = 0;
		after_halt = 0;
		while (after_halt < 4) begin
			@(negedge i_clk);
			op = (o_pc < 64) ? prog[o_pc[5:0]][31:26] : 6'h3f;
			if (first) begin
				check_value("o_pc after reset", o_pc, 0);
				check_value("o_out_valid after reset", 32'(o_out_valid), 0);
				first = 0;
			end
			check_value("o_halted", 32'(o_halted), 32'(halt_due));	// High from the cycle after halt
			if (op == OP_HALT) begin
				halt_due = 1;
			end
			exp_wait = !o_halted && (op == OP_IN) && !i_in_valid;
			check_value("o_in_wait", 32'(o_in_wait), 32'(exp_wait));
			accepted = !o_halted && (op == OP_IN) && i_in_valid;	// i_in_data taken at this edge
			if (o_out_valid) begin
				if (o_halted || o_in_wait) begin
					errors++;
					$display("Error at %0t: output strobe while halted or waiting", $time);
				end else if (out_idx >= exp_out.size()) begin
					errors++;
					$display("Error at %0t: more outputs than the model produced", $time);
				end else begin
					check_value("o_out_data", o_out_data, exp_out[out_idx]);
				end
				out_idx++;
			end
			if (o_halted) begin
				if (halt_seen) begin
					check_value("o_pc after halt", o_pc, halt_pc);
				end else begin
					halt_seen = 1;
					halt_pc = o_pc;
				end
				after_halt++;
			end
			@(posedge i_clk);
			if (accepted) begin
				in_idx++;
			end
			i_in_valid <= random_bit();
			i_in_data <= in_vals[in_idx];
		end
		check_value("output count", out_idx, exp_out.size());
		check_value("final o_pc", halt_pc, model_pc);
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_load_we = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		i_in_valid = 1'b0;
		i_in_data = '0;
		lfsr = LFSR_SEED;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			make_program();
			run_model();
			load_and_reset();
			run_program();
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
cpu_pkg.sv
control_unit.sv
alu.sv
register_file.sv
instruction_memory.sv
data_memory.sv
cpu_top.sv
tb_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_cpu -f build.f -o tb_cpu_sim \
	&& ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1
